// File: rtl/fp_format_pkg.sv
package fp_format_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // binary32 field geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int EXP_W  = 8;
    localparam int FRAC_W = 23;
    localparam int WORD_W = 1 + EXP_W + FRAC_W;   // 32

    localparam logic [EXP_W-1:0] EXP_MAX  = '1;   // inf / nan exponent
    localparam logic [EXP_W-1:0] EXP_BIAS = 8'd127;

    // quiet nan returned for invalid operations
    localparam logic [WORD_W-1:0] CANON_NAN = {1'b0, EXP_MAX, {FRAC_W{1'b1}}};

    ////////////////////////////////////////////////////////////////////////////
    // one float word, seen as raw bits or as its fields
    ////////////////////////////////////////////////////////////////////////////

    typedef union packed {
        logic [WORD_W-1:0] raw;
        struct packed {
            logic              sign;
            logic [EXP_W-1:0]  exp;    // biased
            logic [FRAC_W-1:0] frac;   // hidden bit not stored
        } f;
    } float_word_u;

endpackage

// File: rtl/fp_addsub_pkg.sv
package fp_addsub_pkg;

    import fp_format_pkg::*;

    // guard, round and sticky below the fraction
    localparam int GRS_W = 3;

    // hidden bit + fraction + grs
    localparam int MANT_W = 1 + FRAC_W + GRS_W;   // 27

    localparam int SUM_W   = MANT_W + 1;          // room for the carry
    localparam int SHIFT_W = $clog2(SUM_W);       // leading-one position

    // input sample to result strobe, in clock cycles
    localparam int LATENCY = 5;

endpackage

// File: rtl/fp_stage_if.sv
`timescale 1ns/1ns

// swapped and aligned operands, align section to adder
interface align_if import fp_format_pkg::*, fp_addsub_pkg::*; ();
    logic              valid;
    logic              sub_eff;          // magnitudes are subtracted
    logic              sign_big;
    logic              sign_small_eff;   // op already applied
    logic [EXP_W-1:0]  exp_big;
    logic [MANT_W-1:0] mant_big;
    logic [MANT_W-1:0] mant_small;       // shifted, sticky in bit 0
    logic              special;
    logic [WORD_W-1:0] special_word;
    logic              invalid;

    modport src (output valid, sub_eff, sign_big, sign_small_eff, exp_big,
                        mant_big, mant_small, special, special_word, invalid);
    modport dst (input  valid, sub_eff, sign_big, sign_small_eff, exp_big,
                        mant_big, mant_small, special, special_word, invalid);
endinterface

// raw mantissa sum, adder to normalize/round section
interface sum_if import fp_format_pkg::*, fp_addsub_pkg::*; ();
    logic              valid;
    logic              sign;
    logic [EXP_W-1:0]  exp_big;
    logic [SUM_W-1:0]  sum;              // top bit is the carry
    logic              special;
    logic [WORD_W-1:0] special_word;
    logic              invalid;

    modport src (output valid, sign, exp_big, sum, special, special_word, invalid);
    modport dst (input  valid, sign, exp_big, sum, special, special_word, invalid);
endinterface

// File: rtl/fp_align.sv
`timescale 1ns/1ns

module fp_align import fp_format_pkg::*, fp_addsub_pkg::*; (
    input  logic        i_aclk,
    input  logic        i_rst_n,
    input  logic        i_valid,
    input  logic        i_op_sub,
    input  float_word_u i_a,
    input  float_word_u i_b,
    align_if.src        o_stage
);

    logic              exp_a_ge;
    logic              s1_valid;
    logic              s1_op_sub;
    float_word_u       s1_a;
    float_word_u       s1_b;
    logic              s1_a_nan;
    logic              s1_b_nan;
    logic              s1_a_inf;
    logic              s1_b_inf;
    logic              s1_a_zero;
    logic              s1_b_zero;
    logic              s1_a_ge;        // |a| >= |b|
    logic [EXP_W-1:0]  s1_exp_diff;
    logic              sign_b_eff;
    logic              sub_eff;
    logic              invalid;
    logic [MANT_W-1:0] mant_a;
    logic [MANT_W-1:0] mant_b;
    logic [MANT_W-1:0] mant_s;
    logic [MANT_W-1:0] shifted;
    logic [MANT_W-1:0] lost_mask;
    logic              sticky;

    ////////////////////////////////////////////////////////////////////////////
    // stage 1: classify and compare
    ////////////////////////////////////////////////////////////////////////////

    assign exp_a_ge = i_a.f.exp >= i_b.f.exp;

    always_ff @(posedge i_aclk) begin
        if (!i_rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= i_valid;
        end
    end

    always_ff @(posedge i_aclk) begin
        s1_op_sub   <= i_op_sub;
        s1_a        <= i_a;
        s1_b        <= i_b;
        s1_a_nan    <= (i_a.f.exp == EXP_MAX) && (i_a.f.frac != '0);
        s1_b_nan    <= (i_b.f.exp == EXP_MAX) && (i_b.f.frac != '0);
        s1_a_inf    <= (i_a.f.exp == EXP_MAX) && (i_a.f.frac == '0);
        s1_b_inf    <= (i_b.f.exp == EXP_MAX) && (i_b.f.frac == '0);
        s1_a_zero   <= i_a.f.exp == '0;   // subnormals flushed
        s1_b_zero   <= i_b.f.exp == '0;
        s1_a_ge     <= {i_a.f.exp, i_a.f.frac} >= {i_b.f.exp, i_b.f.frac};
        s1_exp_diff <= exp_a_ge ? i_a.f.exp - i_b.f.exp : i_b.f.exp - i_a.f.exp;
    end

    ////////////////////////////////////////////////////////////////////////////
    // stage 2: swap, align, special result
    ////////////////////////////////////////////////////////////////////////////

    assign sign_b_eff = s1_b.f.sign ^ s1_op_sub;
    assign sub_eff    = s1_a.f.sign ^ sign_b_eff;
    assign invalid    = s1_a_nan | s1_b_nan | (s1_a_inf & s1_b_inf & sub_eff);

    // zero operands lose the hidden bit and the fraction
    assign mant_a = {~s1_a_zero, s1_a.f.frac & {FRAC_W{~s1_a_zero}}, {GRS_W{1'b0}}};
    assign mant_b = {~s1_b_zero, s1_b.f.frac & {FRAC_W{~s1_b_zero}}, {GRS_W{1'b0}}};

    assign mant_s    = s1_a_ge ? mant_b : mant_a;
    assign shifted   = mant_s >> s1_exp_diff;
    assign lost_mask = ~({MANT_W{1'b1}} << s1_exp_diff);   // bits pushed out
    assign sticky    = |(mant_s & lost_mask);

    always_ff @(posedge i_aclk) begin
        if (!i_rst_n) begin
            o_stage.valid <= 1'b0;
        end else begin
            o_stage.valid <= s1_valid;
        end
    end

    always_ff @(posedge i_aclk) begin
        o_stage.sub_eff        <= sub_eff;
        o_stage.sign_big       <= s1_a_ge ? s1_a.f.sign : sign_b_eff;
        o_stage.sign_small_eff <= s1_a_ge ? sign_b_eff : s1_a.f.sign;
        o_stage.exp_big        <= s1_a_ge ? s1_a.f.exp : s1_b.f.exp;
        o_stage.mant_big       <= s1_a_ge ? mant_a : mant_b;
        o_stage.mant_small     <= {shifted[MANT_W-1:1], shifted[0] | sticky};
        o_stage.special        <= s1_a_nan | s1_b_nan | s1_a_inf | s1_b_inf;
        o_stage.invalid        <= invalid;
        if (invalid) begin
            o_stage.special_word <= CANON_NAN;
        end else if (s1_a_inf) begin   // a inf, b same-signed inf or finite
            o_stage.special_word <= {s1_a.f.sign, EXP_MAX, {FRAC_W{1'b0}}};
        end else begin
            o_stage.special_word <= {sign_b_eff, EXP_MAX, {FRAC_W{1'b0}}};
        end
    end

endmodule

// File: rtl/fp_mant_add.sv
`timescale 1ns/1ns

module fp_mant_add import fp_addsub_pkg::*; (
    input  logic i_aclk,
    input  logic i_rst_n,
    align_if.dst i_stage,
    sum_if.src   o_stage
);

    logic [SUM_W-1:0] sum_c;
    logic             sign_c;

    // mant_big >= mant_small, so the difference never goes negative
    always_comb begin
        if (i_stage.sub_eff) begin
            sum_c = {1'b0, i_stage.mant_big} - {1'b0, i_stage.mant_small};
        end else begin
            sum_c = {1'b0, i_stage.mant_big} + {1'b0, i_stage.mant_small};
        end
    end

    // exact zero is +0 unless both terms were negative
    assign sign_c = (sum_c == '0) ? (i_stage.sign_big & i_stage.sign_small_eff)
                                  : i_stage.sign_big;

    ////////////////////////////////////////////////////////////////////////////
    // stage 3 register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_aclk) begin
        if (!i_rst_n) begin
            o_stage.valid <= 1'b0;
        end else begin
            o_stage.valid <= i_stage.valid;
        end
    end

    always_ff @(posedge i_aclk) begin
        o_stage.sign         <= sign_c;
        o_stage.exp_big      <= i_stage.exp_big;
        o_stage.sum          <= sum_c;
        o_stage.special      <= i_stage.special;
        o_stage.special_word <= i_stage.special_word;
        o_stage.invalid      <= i_stage.invalid;
    end

endmodule

// File: rtl/fp_normalize_round.sv
`timescale 1ns/1ns

module fp_normalize_round import fp_format_pkg::*, fp_addsub_pkg::*; (
    input  logic        i_aclk,
    input  logic        i_rst_n,
    sum_if.dst          i_stage,
    output float_word_u o_result,
    output logic        o_result_valid,
    output logic        o_overflow,
    output logic        o_underflow,
    output logic        o_invalid_op
);

    logic [SHIFT_W-1:0]      lead_pos;
    logic [SHIFT_W-1:0]      lshift;
    logic [EXP_W+1:0]        exp_ext;
    logic [MANT_W-1:0]       norm_c;
    logic signed [EXP_W+1:0] exp_c;
    logic                    s4_valid;
    logic                    s4_sign;
    logic signed [EXP_W+1:0] s4_exp;
    logic [MANT_W-1:0]       s4_mant;
    logic                    s4_zero;
    logic                    s4_special;
    logic [WORD_W-1:0]       s4_special_word;
    logic                    s4_invalid;
    logic                    round_up;
    logic [FRAC_W+1:0]       rounded;     // carry + hidden + fraction
    logic signed [EXP_W+1:0] exp_r;
    logic [FRAC_W-1:0]       frac_r;
    float_word_u             result_c;
    logic                    ovf_c;
    logic                    unf_c;

    ////////////////////////////////////////////////////////////////////////////
    // stage 4 finds the leading one and normalizes
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        lead_pos = '0;
        for (int i = 0; i < SUM_W; i++) begin
            if (i_stage.sum[i]) begin
                lead_pos = SHIFT_W'(i);
            end
        end
    end

    assign lshift  = SHIFT_W'(MANT_W - 1) - lead_pos;
    assign exp_ext = {2'b00, i_stage.exp_big};

    always_comb begin
        if (i_stage.sum[SUM_W-1]) begin   // carry out shifts one right
            norm_c = {i_stage.sum[SUM_W-1:2], i_stage.sum[1] | i_stage.sum[0]};
            exp_c  = exp_ext + (EXP_W+2)'(1);
        end else begin
            norm_c = i_stage.sum[MANT_W-1:0] << lshift;
            exp_c  = exp_ext - (EXP_W+2)'(lshift);   // may go negative
        end
    end

    always_ff @(posedge i_aclk) begin
        if (!i_rst_n) begin
            s4_valid <= 1'b0;
        end else begin
            s4_valid <= i_stage.valid;
        end
    end

    always_ff @(posedge i_aclk) begin
        s4_sign         <= i_stage.sign;
        s4_exp          <= exp_c;
        s4_mant         <= norm_c;
        s4_zero         <= i_stage.sum == '0;
        s4_special      <= i_stage.special;
        s4_special_word <= i_stage.special_word;
        s4_invalid      <= i_stage.invalid;
    end

    ////////////////////////////////////////////////////////////////////////////
    // stage 5 rounds to nearest even and picks the result
    ////////////////////////////////////////////////////////////////////////////

    // round bit and then sticky or lsb
    assign round_up = s4_mant[GRS_W-1] & ((|s4_mant[GRS_W-2:0]) | s4_mant[GRS_W]);
    assign rounded  = {1'b0, s4_mant[MANT_W-1:GRS_W]} + (FRAC_W+2)'(round_up);
    assign exp_r    = s4_exp + (EXP_W+2)'(rounded[FRAC_W+1]);
    assign frac_r   = rounded[FRAC_W-1:0];   // all zero after a carry

    always_comb begin
        result_c.raw = '0;
        ovf_c        = 1'b0;
        unf_c        = 1'b0;
        if (s4_special) begin
            result_c.raw = s4_special_word;
        end else if (s4_zero) begin
            result_c.f.sign = s4_sign;
        end else if (exp_r >= $signed({2'b00, EXP_MAX})) begin
            result_c.f.sign = s4_sign;
            result_c.f.exp  = EXP_MAX;          // signed infinity
            ovf_c           = 1'b1;
        end else if (exp_r <= 0) begin
            result_c.f.sign = s4_sign;          // flushed to zero
            unf_c           = 1'b1;
        end else begin
            result_c.f.sign = s4_sign;
            result_c.f.exp  = exp_r[EXP_W-1:0];
            result_c.f.frac = frac_r;
        end
    end

    always_ff @(posedge i_aclk) begin
        if (!i_rst_n) begin
            o_result.raw   <= '0;
            o_result_valid <= 1'b0;
            o_overflow     <= 1'b0;
            o_underflow    <= 1'b0;
            o_invalid_op   <= 1'b0;
        end else begin
            o_result       <= result_c;
            o_result_valid <= s4_valid;
            o_overflow     <= s4_valid & ovf_c;   // flags only with a result
            o_underflow    <= s4_valid & unf_c;
            o_invalid_op   <= s4_valid & s4_invalid;
        end
    end

endmodule

// File: rtl/fp_addsub_top.sv
`timescale 1ns/1ns

module fp_addsub_top import fp_format_pkg::*; (
    input  logic              i_aclk,
    input  logic              i_rst_n,
    input  logic              i_valid,
    input  logic              i_op_sub,      // 1: a - b
    input  logic [WORD_W-1:0] i_a,
    input  logic [WORD_W-1:0] i_b,
    output logic [WORD_W-1:0] o_result,
    output logic              o_result_valid,
    output logic              o_overflow,
    output logic              o_underflow,
    output logic              o_invalid_op
);

    float_word_u a_w;
    float_word_u b_w;
    float_word_u result_w;

    align_if u_align_if ();
    sum_if   u_sum_if ();

    assign a_w.raw  = i_a;
    assign b_w.raw  = i_b;
    assign o_result = result_w.raw;

    ////////////////////////////////////////////////////////////////////////////
    // align (2) -> add (1) -> normalize/round (2)
    ////////////////////////////////////////////////////////////////////////////

    fp_align u_align (
        .i_aclk   (i_aclk),
        .i_rst_n  (i_rst_n),
        .i_valid  (i_valid),
        .i_op_sub (i_op_sub),
        .i_a      (a_w),
        .i_b      (b_w),
        .o_stage  (u_align_if.src)
    );

    fp_mant_add u_mant_add (
        .i_aclk  (i_aclk),
        .i_rst_n (i_rst_n),
        .i_stage (u_align_if.dst),
        .o_stage (u_sum_if.src)
    );

    fp_normalize_round u_normalize_round (
        .i_aclk         (i_aclk),
        .i_rst_n        (i_rst_n),
        .i_stage        (u_sum_if.dst),
        .o_result       (result_w),
        .o_result_valid (o_result_valid),
        .o_overflow     (o_overflow),
        .o_underflow    (o_underflow),
        .o_invalid_op   (o_invalid_op)
    );

endmodule

// File: tests/fp_clk_gen.sv
`timescale 1ns/1ns

module fp_clk_gen (
    output logic o_clk,
    output logic o_rst_n
);

    localparam int HALF_PERIOD  = 10;   // 20 ns period
    localparam int RESET_CYCLES = 8;

    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #1;
        o_rst_n = 1'b1;   // released just after an edge
    end

endmodule

// File: tests/fp_addsub_asserts.sv
`timescale 1ns/1ns

module fp_addsub_asserts import fp_format_pkg::*, fp_addsub_pkg::*; (
    input logic              i_aclk,
    input logic              i_rst_n,
    input logic              i_valid,
    input logic [WORD_W-1:0] i_result,
    input logic              i_result_valid,
    input logic              i_overflow,
    input logic              i_underflow,
    input logic              i_invalid_op
);

    ////////////////////////////////////////////////////////////////////////////
    // pipeline strobe and flag rules
    ////////////////////////////////////////////////////////////////////////////

    valid_latency: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
        i_result_valid == $past(i_valid, LATENCY))
        else $error("result strobe is not the input strobe delayed by the latency");

    flags_need_valid: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
        !i_result_valid |-> !(i_overflow || i_underflow || i_invalid_op))
        else $error("flag raised without a result");

    ovf_unf_exclusive: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
        !(i_overflow && i_underflow))
        else $error("overflow and underflow raised together");

    // sign is free, the rest must be infinity
    ovf_gives_inf: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
        i_overflow |-> (i_result[WORD_W-2:0] == {EXP_MAX, {FRAC_W{1'b0}}}))
        else $error("overflow without an infinity result");

endmodule

bind fp_addsub_top fp_addsub_asserts u_asserts (
    .i_aclk         (i_aclk),
    .i_rst_n        (i_rst_n),
    .i_valid        (i_valid),
    .i_result       (o_result),
    .i_result_valid (o_result_valid),
    .i_overflow     (o_overflow),
    .i_underflow    (o_underflow),
    .i_invalid_op   (o_invalid_op)
);

// File: tests/fp_addsub_tb.sv
`timescale 1ns/1ns

module fp_addsub_tb import fp_format_pkg::*, fp_addsub_pkg::*; ();

    localparam int RESET_CYCLES = 8;
    localparam int DRIVE_DELAY  = 1;   // ns after the rising edge
    localparam int NUM_ROWS     = 19;
    localparam int TIMEOUT_CYCLES = NUM_ROWS + LATENCY + RESET_CYCLES + 20;

    // flags are {overflow, underflow, invalid}
    typedef struct packed {
        logic [WORD_W-1:0] a;
        logic [WORD_W-1:0] b;
        logic              op;       // set for a - b
        logic [WORD_W-1:0] result;
        logic [2:0]        flags;
    } row_t;

    typedef struct {
        int idx;
        int cycle;   // cycle count when driven
    } pending_t;

    localparam row_t ROWS [NUM_ROWS] = '{
        '{32'h3FC00000, 32'h40100000, 1'b0, 32'h40700000, 3'b000},  // 1.5 + 2.25
        '{32'h3F800000, 32'h40400000, 1'b1, 32'hC0000000, 3'b000},  // 1 - 3
        '{32'hBFC00000, 32'h40100000, 1'b0, 32'h3F400000, 3'b000},  // -1.5 + 2.25
        '{32'h40000000, 32'h40000000, 1'b0, 32'h40800000, 3'b000},  // carry out
        '{32'h3F800000, 32'h33800000, 1'b0, 32'h3F800000, 3'b000},  // tie to even
        '{32'h3F800000, 32'h34400000, 1'b0, 32'h3F800002, 3'b000},  // 1 + 3*2^-24
        '{32'h3F800001, 32'h33800000, 1'b0, 32'h3F800002, 3'b000},  // tie with odd lsb
        '{32'h3F800000, 32'h2B800000, 1'b0, 32'h3F800000, 3'b000},  // sticky only
        '{32'h3F800000, 32'h33800001, 1'b0, 32'h3F800001, 3'b000},  // sticky breaks the tie
        '{32'h40700000, 32'h40700000, 1'b1, 32'h00000000, 3'b000},  // x - x
        '{32'h80000000, 32'h80000000, 1'b0, 32'h80000000, 3'b000},  // -0 + -0
        '{32'h00000000, 32'h40100000, 1'b0, 32'h40100000, 3'b000},  // 0 + y
        '{32'h3F800001, 32'h3F800000, 1'b1, 32'h34000000, 3'b000},  // big left shift
        '{32'h7FC00000, 32'h3F800000, 1'b0, 32'h7FFFFFFF, 3'b001},  // nan in
        '{32'h7F800000, 32'h7F800000, 1'b1, 32'h7FFFFFFF, 3'b001},  // inf - inf
        '{32'hFF800000, 32'h3F800000, 1'b0, 32'hFF800000, 3'b000},  // -inf + 1
        '{32'h3F800000, 32'hFF800000, 1'b1, 32'h7F800000, 3'b000},  // 1 - -inf
        '{32'h7F7FFFFF, 32'h7F7FFFFF, 1'b0, 32'h7F800000, 3'b100},  // max + max
        '{32'h00C00000, 32'h00800000, 1'b1, 32'h00000000, 3'b010}   // below min normal
    };

    logic              aclk;
    logic              rst_n;
    logic              i_valid;
    logic              i_op_sub;
    logic [WORD_W-1:0] i_a;
    logic [WORD_W-1:0] i_b;
    logic [WORD_W-1:0] o_result;
    logic              o_result_valid;
    logic              o_overflow;
    logic              o_underflow;
    logic              o_invalid_op;

    pending_t pend_q[$];
    int       cycle_count = 0;
    int       check_count = 0;
    int       error_count = 0;
    logic     due_now;

    fp_clk_gen u_clk_gen (
        .o_clk   (aclk),
        .o_rst_n (rst_n)
    );

    fp_addsub_top i_dut (
        .i_aclk         (aclk),
        .i_rst_n        (rst_n),
        .i_valid        (i_valid),
        .i_op_sub       (i_op_sub),
        .i_a            (i_a),
        .i_b            (i_b),
        .o_result       (o_result),
        .o_result_valid (o_result_valid),
        .o_overflow     (o_overflow),
        .o_underflow    (o_underflow),
        .o_invalid_op   (o_invalid_op)
    );

    always @(posedge aclk) cycle_count <= cycle_count + 1;

    task automatic compare_result(input int idx);
        row_t        r;
        float_word_u got_w;
        r         = ROWS[idx];
        got_w.raw = o_result;
        check_count++;
        assert (o_result == r.result && {o_overflow, o_underflow, o_invalid_op} == r.flags)
        else begin
            error_count++;
            $display("[FAIL] %0t row %0d: %h %s %h got %h (s%0d e%h f%h) flags %b, exp %h flags %b",
                     $time, idx, r.a, r.op ? "-" : "+", r.b, got_w.raw, got_w.f.sign,
                     got_w.f.exp, got_w.f.frac, {o_overflow, o_underflow, o_invalid_op},
                     r.result, r.flags);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // output monitor sampled mid-cycle
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge aclk) begin
        if (rst_n) begin
            due_now = pend_q.size() != 0 && pend_q[0].cycle + LATENCY == cycle_count;
            assert (o_result_valid == due_now) else begin
                error_count++;
                if (o_result_valid)
                    $display("%0t: result strobe seen with no input due", $time);
                else
                    $display("%0t: result for row %0d did not arrive", $time, pend_q[0].idx);
            end
            if (due_now) begin
                if (o_result_valid)
                    compare_result(pend_q[0].idx);
                void'(pend_q.pop_front());
            end
        end
    end

    initial begin : watchdog
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("timeout: run still going after %0d cycles", cycle_count);
        $display("Some tests failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus with one row per cycle
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        pending_t p;
        i_valid  = 1'b0;
        i_op_sub = 1'b0;
        i_a      = '0;
        i_b      = '0;
        wait (rst_n === 1'b1);
        for (int i = 0; i < NUM_ROWS; i++) begin
            @(posedge aclk);
            #DRIVE_DELAY;
            i_valid  = 1'b1;
            i_op_sub = ROWS[i].op;
            i_a      = ROWS[i].a;
            i_b      = ROWS[i].b;
            p.idx    = i;
            p.cycle  = cycle_count;
            pend_q.push_back(p);
        end
        @(posedge aclk);
        #DRIVE_DELAY;
        i_valid = 1'b0;
        i_a     = '0;
        i_b     = '0;
        while (pend_q.size() != 0) @(posedge aclk);
        repeat (LATENCY + 2) @(posedge aclk);   // strobe must stay low in the idle tail
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0 && check_count == NUM_ROWS) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: src.f
rtl/fp_format_pkg.sv
rtl/fp_addsub_pkg.sv
rtl/fp_stage_if.sv
rtl/fp_align.sv
rtl/fp_mant_add.sv
rtl/fp_normalize_round.sv
rtl/fp_addsub_top.sv
tests/fp_clk_gen.sv
tests/fp_addsub_asserts.sv
tests/fp_addsub_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= fp_addsub_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(wildcard rtl/*.sv tests/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^All tests passed$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
